/* video_params.svh */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// horizontal timing in character cycles
`define HPERIOD      9'd448
`define HBLNK_BEG    9'd0
`define HSYNC_BEG    9'd10
`define HSYNC_END    9'd43
`define HBLNK_END    9'd88

// pixel window per raster width
`define HPIX_BEG_256 9'd140
`define HPIX_END_256 9'd396
`define HPIX_BEG_320 9'd108
`define HPIX_END_320 9'd428
`define HPIX_BEG_360 9'd88
`define HPIX_END_360 9'd448 // runs to the end of the line

// fetch runs ahead of the pixels
`define FETCH_PRE_ZX 9'd18
`define FETCH_PRE_TM 9'd10

// tiles and x-scroll fetch, counted from hsync begin
`define TFETCH_BEG   9'd2
`define TFETCH_END   9'd34  // 16 words of tiles
`define XSFETCH_BEG  9'd40
`define XSFETCH_END  9'd44  // 2 words of x-scrolls

`define SCANIN_BEG   9'd88  // scan-in of a line begins
`define HINT_BEG     9'd445

// vertical timing in lines
`define VPERIOD      9'd320
`define VBLNK_BEG    9'd0
`define VSYNC_BEG    9'd4
`define VSYNC_END    9'd8
`define VBLNK_END    9'd32

// vertical pixel window per resolution
`define VPIX_BEG_192 9'd88
`define VPIX_END_192 9'd280
`define VPIX_BEG_200 9'd84
`define VPIX_END_200 9'd284
`define VPIX_BEG_240 9'd64
`define VPIX_END_240 9'd304

`define VINT_LINE    9'd0

// mode register map
`define REG_MODE     2'd0
`define REG_VRES     2'd1
`define REG_INIT     2'd2

`endif

/* video_pkg.sv */
package video_pkg;

	// wishbone classic, master to slave
	typedef struct packed
	{
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr; // register select
		logic [7:0] dat; // write data
	} wb_req_t;

	// slave to master
	typedef struct packed
	{
		logic       ack;
		logic [7:0] dat; // read data, valid with ack
	} wb_rsp_t;

	// current video mode as held by the mode registers
	typedef struct packed
	{
		logic [1:0] rres; // raster width 00=256 01=320 10=320 11=360
		logic       tm;   // tiles mode
		logic       brd;  // border only, no linear gfx
		logic [1:0] vres; // lines 00=192 01=200 1x=240
	} video_mode_t;

	// raster levels and pulses
	typedef struct packed
	{
		logic hblank;
		logic hsync;
		logic hpix;
		logic vblank;
		logic vsync;
		logic vpix;
		logic line_start;
		logic hsync_start;
		logic scanin_start;
		logic frame_int;
	} sync_out_t;

	// open and close the fetcher windows, one clock each
	typedef struct packed
	{
		logic fetch_start;
		logic fetch_end;
		logic tfetch_start;
		logic tfetch_end;
		logic xsfetch_start;
		logic xsfetch_end;
	} fetch_strobe_t;

endpackage

/* video_clk_strobe.sv */
`timescale 1ns/1ns

// character clock, one cycle is four system clocks
module video_clk_strobe
(
	input  logic clk,
	input  logic reset,
	input  logic init,      // restart phase at 0
	output logic post_cbeg, // first clock of a cycle
	output logic pre_cend,  // clock before cend
	output logic cend       // last clock of a cycle
);
	logic [1:0] phase;

	always_ff @(posedge clk)
	begin
		if (reset || init)
		begin
			phase     <= 2'd0;
			post_cbeg <= 1'b0;
			pre_cend  <= 1'b0;
			cend      <= 1'b0;
		end
		else
		begin
			phase     <= phase + 2'd1; // wraps every four clocks
			// strobes follow the phase they decode by one clock
			post_cbeg <= (phase == 2'd0);
			pre_cend  <= (phase == 2'd2);
			cend      <= (phase == 2'd3);
		end
	end

	// phase 1 has no strobe of its own
	// its clock stays idle between post_cbeg and pre_cend

endmodule

/* video_sync_h.sv */
`timescale 1ns/1ns
`include "video_params.svh"

// horizontal raster timing, 448 character cycles per line
module video_sync_h
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     init,         // restart line at position 0
	input  logic                     cend,         // character cycle end
	input  logic                     pre_cend,     // one clock ahead of cend
	input  video_pkg::video_mode_t   mode,
	input  logic                     vpix,         // vertical gfx window
	input  logic                     vtfetch,      // vertical tiles fetch window
	output logic                     hblank,
	output logic                     hsync,
	output logic                     hpix,         // pixels are being output
	output logic                     line_start,   // coincide with cend
	output logic                     hsync_start,
	output logic                     scanin_start,
	output logic                     hint_start,   // raw int position, qualified in sync_v
	output logic                     line_end,     // last cend of the line
	output video_pkg::fetch_strobe_t fetch
);
	logic [8:0] hcount;  // character position in the line
	logic [8:0] hp_beg;  // pixel window begin for rres
	logic [8:0] hp_end;
	logic [8:0] hp_clr;  // end position as the counter sees it
	logic [8:0] f_pre;   // fetch lead
	logic       gfx_en;  // gfx fetch allowed on this line
	logic       tile_en; // tiles fetch allowed on this line

	// pixel window by raster width
	always_comb
	begin
		case (mode.rres)
			2'b00:
			begin
				hp_beg = `HPIX_BEG_256;
				hp_end = `HPIX_END_256;
			end
			2'b11:
			begin
				hp_beg = `HPIX_BEG_360;
				hp_end = `HPIX_END_360;
			end
			default: // 01 and 10 are both 320
			begin
				hp_beg = `HPIX_BEG_320;
				hp_end = `HPIX_END_320;
			end
		endcase
	end

	// the 360 window ends at 448 which the counter shows as 0
	assign hp_clr  = (hp_end == `HPERIOD) ? 9'd0 : hp_end;
	assign f_pre   = mode.tm ? `FETCH_PRE_TM : `FETCH_PRE_ZX; // tiles need less lead
	assign gfx_en  = vpix && !mode.brd;
	assign tile_en = vtfetch && mode.tm;

	assign line_end = cend && (hcount == `HPERIOD - 9'd1);

	// line counter
	always_ff @(posedge clk)
	begin
		if (reset || init)
			hcount <= 9'd0;
		else if (cend)
		begin
			if (hcount == `HPERIOD - 9'd1)
				hcount <= 9'd0;
			else
				hcount <= hcount + 9'd1;
		end
	end

	// levels move on cend only
	always_ff @(posedge clk)
	begin
		if (reset || init)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
			hpix   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == `HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == `HBLNK_END)
				hblank <= 1'b0;

			if (hcount == `HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == `HSYNC_END)
				hsync <= 1'b0;

			if (hcount == hp_beg)
				hpix <= 1'b1;
			else if (hcount == hp_clr)
				hpix <= 1'b0;
		end
	end

	// position pulses, taken at pre_cend so they land on the next cend
	always_ff @(posedge clk)
	begin
		if (reset || init)
		begin
			hsync_start  <= 1'b0;
			line_start   <= 1'b0;
			scanin_start <= 1'b0;
			hint_start   <= 1'b0;
			fetch        <= '0;
		end
		else
		begin
			hsync_start  <= pre_cend && (hcount == `HSYNC_BEG);
			line_start   <= pre_cend && (hcount == `HBLNK_END);
			scanin_start <= pre_cend && (hcount == `SCANIN_BEG);
			hint_start   <= pre_cend && (hcount == `HINT_BEG);

			// gfx window opens f_pre cycles before the pixels
			fetch.fetch_start <= pre_cend && gfx_en && (hcount == hp_beg - f_pre);
			fetch.fetch_end   <= pre_cend && gfx_en && (hcount == hp_end - f_pre);

			// tiles then x-scrolls, both during hblank after hsync
			fetch.tfetch_start  <= pre_cend && tile_en &&
				(hcount == `HSYNC_BEG + `TFETCH_BEG);
			fetch.tfetch_end    <= pre_cend && tile_en &&
				(hcount == `HSYNC_BEG + `TFETCH_END);
			fetch.xsfetch_start <= pre_cend && tile_en &&
				(hcount == `HSYNC_BEG + `XSFETCH_BEG);
			fetch.xsfetch_end   <= pre_cend && tile_en &&
				(hcount == `HSYNC_BEG + `XSFETCH_END);
		end
	end

endmodule

/* video_sync_v.sv */
`timescale 1ns/1ns
`include "video_params.svh"

// vertical raster timing, 320 lines per frame
module video_sync_v
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   init,       // restart frame at line 0
	input  logic                   line_end,   // last cend of a line
	input  logic                   hint_start, // int position in every line
	input  video_pkg::video_mode_t mode,
	output logic                   vblank,
	output logic                   vsync,
	output logic                   vpix,       // vertical gfx window
	output logic                   vtfetch,    // vpix one line early
	output logic                   frame_int   // once per frame
);
	logic [8:0] vcount; // current line
	logic [8:0] vp_beg; // vertical pixel window for vres
	logic [8:0] vp_end;

	always_comb
	begin
		case (mode.vres)
			2'b00:
			begin
				vp_beg = `VPIX_BEG_192;
				vp_end = `VPIX_END_192;
			end
			2'b01:
			begin
				vp_beg = `VPIX_BEG_200;
				vp_end = `VPIX_END_200;
			end
			default: // 1x is 240
			begin
				vp_beg = `VPIX_BEG_240;
				vp_end = `VPIX_END_240;
			end
		endcase
	end

	// frame counter
	always_ff @(posedge clk)
	begin
		if (reset || init)
			vcount <= 9'd0;
		else if (line_end)
		begin
			if (vcount == `VPERIOD - 9'd1)
				vcount <= 9'd0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// levels change at the end of a line only
	always_ff @(posedge clk)
	begin
		if (reset || init)
		begin
			vblank  <= 1'b0;
			vsync   <= 1'b0;
			vpix    <= 1'b0;
			vtfetch <= 1'b0;
		end
		else if (line_end)
		begin
			if (vcount == `VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == `VBLNK_END)
				vblank <= 1'b0;

			if (vcount == `VSYNC_BEG)
				vsync <= 1'b1;
			else if (vcount == `VSYNC_END)
				vsync <= 1'b0;

			if (vcount == vp_beg)
				vpix <= 1'b1;
			else if (vcount == vp_end)
				vpix <= 1'b0;

			// tiles for a line are fetched during the line before it
			if (vcount == vp_beg - 9'd1)
				vtfetch <= 1'b1;
			else if (vcount == vp_end - 9'd1)
				vtfetch <= 1'b0;
		end
	end

	// vcount is stable at hint time, it only moves at line_end
	assign frame_int = hint_start && (vcount == `VINT_LINE);

endmodule

/* video_mode_regs.sv */
`timescale 1ns/1ns
`include "video_params.svh"

// mode registers on a wishbone classic slave
module video_mode_regs
(
	input  logic                   clk,
	input  logic                   reset,
	input  video_pkg::wb_req_t     wb_req,
	output video_pkg::wb_rsp_t     wb_rsp,
	output video_pkg::video_mode_t mode,
	output logic                   init    // one clock wide with the ack of an init write
);
	logic       ack;
	logic       access; // new cycle seen so ack rises next clock
	logic [7:0] rd_dat;

	// ack low in between keeps a held stb to every other clock
	assign access = wb_req.cyc && wb_req.stb && !ack;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack  <= 1'b0;
			init <= 1'b0;
			mode <= '0; // 256 by 192 with tiles and border only off
		end
		else
		begin
			ack  <= access;
			init <= access && wb_req.we && (wb_req.adr == `REG_INIT);
			if (access && wb_req.we)
			begin
				case (wb_req.adr)
					`REG_MODE:
					begin
						mode.rres <= wb_req.dat[1:0];
						mode.tm   <= wb_req.dat[2];
						mode.brd  <= wb_req.dat[3];
					end
					`REG_VRES:
						mode.vres <= wb_req.dat[1:0];
					default:; // init has no storage and 3 is unused
				endcase
			end
		end
	end

	// read data latched with ack
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_dat <= 8'd0;
		else if (access)
		begin
			case (wb_req.adr)
				`REG_MODE: rd_dat <= {4'd0, mode.brd, mode.tm, mode.rres};
				`REG_VRES: rd_dat <= {6'd0, mode.vres};
				default:   rd_dat <= 8'd0; // init and 3 read zero
			endcase
		end
	end

	assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

/* video_sync_top.sv */
`timescale 1ns/1ns

// raster timing generator
module video_sync_top
(
	input  logic                     clk,
	input  logic                     reset,
	input  video_pkg::wb_req_t       wb_req,
	output video_pkg::wb_rsp_t       wb_rsp,
	output video_pkg::sync_out_t     sync,
	output video_pkg::fetch_strobe_t fetch
);
	import video_pkg::*;

	video_mode_t mode;
	logic        init;      // counter restart from the init register
	logic        post_cbeg; // character clock strobes
	logic        pre_cend;
	logic        cend;
	logic        hblank;
	logic        hsync;
	logic        hpix;
	logic        line_start;
	logic        hsync_start;
	logic        scanin_start;
	logic        hint_start;
	logic        line_end;
	logic        vblank;
	logic        vsync;
	logic        vpix;
	logic        vtfetch;
	logic        frame_int;

	video_clk_strobe video_clk_strobe_i
	(
		.clk       (clk),
		.reset     (reset),
		.init      (init),
		.post_cbeg (post_cbeg),
		.pre_cend  (pre_cend),
		.cend      (cend)
	);

	video_mode_regs video_mode_regs_i
	(
		.clk    (clk),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.mode   (mode),
		.init   (init)
	);

	video_sync_h video_sync_h_i
	(
		.clk          (clk),
		.reset        (reset),
		.init         (init),
		.cend         (cend),
		.pre_cend     (pre_cend),
		.mode         (mode),
		.vpix         (vpix),    // vertical windows gate the fetch strobes
		.vtfetch      (vtfetch),
		.hblank       (hblank),
		.hsync        (hsync),
		.hpix         (hpix),
		.line_start   (line_start),
		.hsync_start  (hsync_start),
		.scanin_start (scanin_start),
		.hint_start   (hint_start),
		.line_end     (line_end),
		.fetch        (fetch)
	);

	video_sync_v video_sync_v_i
	(
		.clk        (clk),
		.reset      (reset),
		.init       (init),
		.line_end   (line_end),
		.hint_start (hint_start),
		.mode       (mode),
		.vblank     (vblank),
		.vsync      (vsync),
		.vpix       (vpix),
		.vtfetch    (vtfetch),
		.frame_int  (frame_int)
	);

	assign sync = '{
		hblank:       hblank,
		hsync:        hsync,
		hpix:         hpix,
		vblank:       vblank,
		vsync:        vsync,
		vpix:         vpix,
		line_start:   line_start,
		hsync_start:  hsync_start,
		scanin_start: scanin_start,
		frame_int:    frame_int
	};

endmodule

/* video_sync_tb_clk.sv */
`timescale 1ns/1ns

// free running testbench clock
module video_sync_tb_clk
#(
	parameter int PERIOD = 100 // ns
)
(
	output logic clk
);
	initial
		clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

/* video_sync_asserts.sv */
`timescale 1ns/1ns

// protocol and timing properties of the raster generator
module video_sync_asserts
(
	input logic                     clk,
	input logic                     reset,
	input video_pkg::wb_rsp_t       wb_rsp,
	input video_pkg::sync_out_t     sync,
	input video_pkg::fetch_strobe_t fetch,
	input video_pkg::video_mode_t   mode,
	input logic                     post_cbeg,
	input logic                     pre_cend,
	input logic                     cend
);
	int fail_count = 0; // assertion failures so far

	// single clock ack
	ack_one_clock: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
	else
	begin
		$error("ack held for two clocks");
		fail_count++;
	end

	sync_in_blank: assert property (@(posedge clk) disable iff (reset)
		sync.hsync |-> sync.hblank)
	else
	begin
		$error("hsync outside hblank");
		fail_count++;
	end

	// gating sees the mode of the clock before the pulse
	no_fetch_in_border: assert property (@(posedge clk) disable iff (reset)
		fetch.fetch_start |-> !$past(mode.brd))
	else
	begin
		$error("fetch_start in border only mode");
		fail_count++;
	end

	strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
		$onehot0({post_cbeg, pre_cend, cend}))
	else
	begin
		$error("character strobes overlap");
		fail_count++;
	end

endmodule

bind video_sync_top video_sync_asserts video_sync_asserts_i
(
	.clk       (clk),
	.reset     (reset),
	.wb_rsp    (wb_rsp),
	.sync      (sync),
	.fetch     (fetch),
	.mode      (mode),
	.post_cbeg (post_cbeg),
	.pre_cend  (pre_cend),
	.cend      (cend)
);

/* video_sync_tb.sv */
`timescale 1ns/1ns
`include "video_params.svh"

module video_sync_tb;
	import video_pkg::*;

	localparam int LINE_CLKS  = int'(`HPERIOD) * 4;     // four clocks per character
	localparam int FRAME_CLKS = int'(`VPERIOD) * LINE_CLKS;
	localparam int LIMIT      = 3 * FRAME_CLKS + 110 * LINE_CLKS + 4000;

	logic          clk;
	logic          reset;
	wb_req_t       wb_req;
	wb_rsp_t       wb_rsp;
	sync_out_t     sync;
	fetch_strobe_t fetch;

	integer      seed;
	int unsigned cycles;
	logic [7:0]  val;
	logic [7:0]  rd;

	// reference model state
	int unsigned   m_k; // clocks since reset or init
	logic          m_hblank, m_hsync, m_hpix;
	logic          m_vblank, m_vsync, m_vpix, m_vtfetch;
	logic          m_line_start, m_hsync_start, m_scanin_start, m_hint;
	fetch_strobe_t m_fetch;
	video_mode_t   m_mode;
	logic          m_ack, m_init, m_rd;
	logic [7:0]    m_dat;

	video_sync_tb_clk #(.PERIOD(100)) clk_gen_i (.clk(clk));

	video_sync_top video_sync_top_i
	(
		.clk    (clk),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.sync   (sync),
		.fetch  (fetch)
	);

	// characters completed after clock kk where the first cend is clock 4
	function automatic int unsigned char_count(int unsigned kk);
		return (kk == 0) ? 0 : (kk - 1) / 4;
	endfunction

	function automatic int hpos(int unsigned kk);
		return char_count(kk) % 448;
	endfunction

	function automatic int vpos(int unsigned kk);
		return (char_count(kk) / 448) % 320;
	endfunction

	function automatic logic level_next(logic cur, int n, int beg, int fin);
		if (n == beg)
			return 1'b1;
		if (n == fin)
			return 1'b0;
		return cur;
	endfunction

	function automatic int hpix_beg(video_mode_t m);
		return (m.rres == 2'b00) ? 140 : (m.rres == 2'b11) ? 88 : 108;
	endfunction

	function automatic int hpix_end(video_mode_t m);
		return (m.rres == 2'b00) ? 396 : (m.rres == 2'b11) ? 448 : 428;
	endfunction

	function automatic int vpix_beg(video_mode_t m);
		return (m.vres == 2'b00) ? 88 : (m.vres == 2'b01) ? 84 : 64;
	endfunction

	function automatic int vpix_end(video_mode_t m);
		return (m.vres == 2'b00) ? 280 : (m.vres == 2'b01) ? 284 : 304;
	endfunction

	// fetch strobes taken at a pre_cend with counter h
	function automatic fetch_strobe_t ref_fetch(int h, video_mode_t m, logic vp, logic vt);
		fetch_strobe_t f;
		int lead;
		logic gfx;
		logic tile;
		lead = m.tm ? 10 : 18;
		gfx  = vp && !m.brd;
		tile = vt && m.tm;
		f.fetch_start   = gfx && (h == hpix_beg(m) - lead);
		f.fetch_end     = gfx && (h == hpix_end(m) - lead);
		f.tfetch_start  = tile && (h == 12);
		f.tfetch_end    = tile && (h == 44);
		f.xsfetch_start = tile && (h == 50);
		f.xsfetch_end   = tile && (h == 54);
		return f;
	endfunction

	function automatic sync_out_t ref_sync();
		sync_out_t s;
		s.hblank       = m_hblank;
		s.hsync        = m_hsync;
		s.hpix         = m_hpix;
		s.vblank       = m_vblank;
		s.vsync        = m_vsync;
		s.vpix         = m_vpix;
		s.line_start   = m_line_start;
		s.hsync_start  = m_hsync_start;
		s.scanin_start = m_scanin_start;
		s.frame_int    = m_hint && (vpos(m_k) == 0); // hint on line 0 only
		return s;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s mismatch, got %0h expected %0h",
				$time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// advance the model by one clock from the values seen before the edge
	task automatic model_step();
		int unsigned ko;
		int h;
		int v;
		logic cend_o;
		logic pre_o;
		logic access;
		ko     = m_k;
		h      = hpos(ko);
		v      = vpos(ko);
		cend_o = (ko % 4 == 0) && (ko >= 4);
		pre_o  = (ko % 4 == 3);
		access = wb_req.cyc && wb_req.stb && !m_ack;
		if (reset || m_init)
		begin
			m_k = 0;
			{m_hblank, m_hsync, m_hpix, m_vblank, m_vsync, m_vpix, m_vtfetch} = '0;
			{m_line_start, m_hsync_start, m_scanin_start, m_hint} = '0;
			m_fetch = '0;
		end
		else
		begin
			m_k = ko + 1;
			// pulses see the windows from before this clock
			m_hsync_start  = pre_o && (h == 10);
			m_line_start   = pre_o && (h == 88);
			m_scanin_start = pre_o && (h == 88);
			m_hint         = pre_o && (h == 445);
			m_fetch = pre_o ? ref_fetch(h, m_mode, m_vpix, m_vtfetch) : '0;
			if (cend_o)
			begin
				m_hblank = level_next(m_hblank, h, 0, 88);
				m_hsync  = level_next(m_hsync, h, 10, 43);
				m_hpix   = level_next(m_hpix, h, hpix_beg(m_mode), hpix_end(m_mode) % 448);
			end
			if (cend_o && h == 447) // line end
			begin
				m_vblank  = level_next(m_vblank, v, 0, 32);
				m_vsync   = level_next(m_vsync, v, 4, 8);
				m_vpix    = level_next(m_vpix, v, vpix_beg(m_mode), vpix_end(m_mode));
				m_vtfetch = level_next(m_vtfetch, v, vpix_beg(m_mode) - 1,
					vpix_end(m_mode) - 1);
			end
		end
		if (reset)
		begin
			m_mode = '0;
			m_ack  = 1'b0;
			m_init = 1'b0;
			m_rd   = 1'b0;
		end
		else
		begin
			if (access && !wb_req.we)
				m_dat = (wb_req.adr == 2'd0) ? {4'd0, m_mode.brd, m_mode.tm, m_mode.rres} :
					(wb_req.adr == 2'd1) ? {6'd0, m_mode.vres} : 8'd0;
			if (access && wb_req.we && wb_req.adr == 2'd0)
				{m_mode.brd, m_mode.tm, m_mode.rres} = wb_req.dat[3:0];
			if (access && wb_req.we && wb_req.adr == 2'd1)
				m_mode.vres = wb_req.dat[1:0];
			m_rd   = access && !wb_req.we;
			m_init = access && wb_req.we && (wb_req.adr == 2'd2);
			m_ack  = access;
		end
	endtask

	// model steps on the rising edge and is compared at the falling edge
	always
	begin
		@(posedge clk);
		model_step();
		@(negedge clk);
		check("sync", sync, ref_sync());
		check("fetch", fetch, m_fetch);
		check("ack", wb_rsp.ack, m_ack);
		if (m_ack && m_rd)
			check("read data", wb_rsp.dat, m_dat);
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("Timeout: the test did not finish within %0d clocks", LIMIT);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	// one classic cycle held until ack
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] dat,
		output logic [7:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do
		begin
			@(negedge clk);
			waited++;
			if (waited > 8)
			begin
				$display("Wishbone slave gave no ack within 8 clocks");
				$display("** FAIL **");
				$fatal(1, "no ack");
			end
		end
		while (!wb_rsp.ack);
		rdat   = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [1:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input logic [1:0] adr, output logic [7:0] dat);
		bus_cycle(1'b0, adr, 8'd0, dat);
	endtask

	task automatic wait_lines(input int n);
		repeat (n * LINE_CLKS) @(negedge clk);
	endtask

	initial
	begin
		seed        = 32'he6ce_28bb;
		cycles      = 0;
		wb_req      = '0;
		reset       = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check("read data after reset", wb_rsp.dat, 8'd0);

		wait_lines(100); // default mode from reset

		// random mode values read back
		repeat (8)
		begin
			val = $random(seed);
			bus_write(`REG_MODE, val);
			bus_read(`REG_MODE, rd);
			check("mode readback", rd, {4'd0, val[3:0]});
			val = $random(seed);
			bus_write(`REG_VRES, val);
			bus_read(`REG_VRES, rd);
			check("vres readback", rd, {6'd0, val[1:0]});
		end
		bus_write(2'd3, $random(seed));
		bus_read(2'd3, rd);
		check("unused address", rd, 8'd0);
		bus_read(`REG_INIT, rd);
		check("init readback", rd, 8'd0);

		// sweep widths and tiles mode over a 192 line frame
		bus_write(`REG_MODE, 8'h00);
		bus_write(`REG_VRES, 8'h00);
		bus_write(`REG_INIT, $random(seed));
		wait_lines(86);
		for (int r = 0; r < 4; r++)
		begin
			for (int t = 0; t < 2; t++)
			begin
				bus_write(`REG_MODE, {5'd0, t[0], r[1:0]});
				wait_lines(22);
			end
		end
		bus_write(`REG_MODE, 8'b1001); // border only
		wait_lines(10);
		bus_write(`REG_MODE, 8'b1111);
		wait_lines(10);
		bus_write(`REG_MODE, 8'b0100);
		wait_lines(38);

		// frame at 200 lines
		bus_write(`REG_MODE, 8'b0111);
		bus_write(`REG_VRES, 8'h01);
		bus_write(`REG_INIT, 8'h00);
		wait_lines(320);

		// 240 line frame with either 1x code
		val = $random(seed);
		bus_write(`REG_MODE, 8'b0101);
		bus_write(`REG_VRES, {6'd0, 1'b1, val[0]});
		bus_write(`REG_INIT, 8'hff);
		wait_lines(320);
		wait_lines(2);

		if (video_sync_top_i.video_sync_asserts_i.fail_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
video_pkg.sv
video_clk_strobe.sv
video_sync_h.sv
video_sync_v.sv
video_mode_regs.sv
video_sync_top.sv
video_sync_tb_clk.sv
video_sync_asserts.sv
video_sync_tb.sv
